//--- count_pkg.sv
package count_pkg;

    // light colour of one countdown phase
    typedef enum logic [1:0] {
        red    = 2'd0,
        green  = 2'd1,
        yellow = 2'd2
    } light_t;

    // digit shown on the matrix
    typedef logic [2:0] digit_t;

    // largest digit the glyph set can show
    localparam digit_t max_digit = 3'd5;

    // one step of the countdown
    typedef struct packed {
        digit_t digit;
        light_t light;
    } count_rec_t;

endpackage

//--- countdown_display.sv
module countdown_display #(
    parameter int red_len          = 5,
    parameter int green_len        = 5,
    parameter int yellow_len       = 3,
    parameter int fifo_depth       = 4,
    parameter int frames_per_digit = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tick,
    output matrix_pkg::matrix_drive_t drive
);
    import count_pkg::*;

    logic       seq_valid;
    logic       seq_ready;
    count_rec_t seq_rec;
    logic       disp_valid;
    logic       disp_ready;
    count_rec_t disp_rec;

    countdown_seq #(
        .red_len    (red_len),
        .green_len  (green_len),
        .yellow_len (yellow_len)
    ) u_countdown_seq (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .seq_ready (seq_ready),
        .seq_valid (seq_valid),
        .seq_rec   (seq_rec)
    );

    digit_fifo #(
        .fifo_depth (fifo_depth)
    ) u_digit_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (seq_valid),
        .in_ready  (seq_ready),
        .in_rec    (seq_rec),
        .out_valid (disp_valid),
        .out_ready (disp_ready),
        .out_rec   (disp_rec)
    );

    matrix_scan #(
        .frames_per_digit (frames_per_digit)
    ) u_matrix_scan (
        .clk      (clk),
        .rst      (rst),
        .in_valid (disp_valid),
        .in_ready (disp_ready),
        .in_rec   (disp_rec),
        .drive    (drive)
    );

endmodule

//--- countdown_seq.sv
module countdown_seq #(
    parameter int red_len    = 5,
    parameter int green_len  = 5,
    parameter int yellow_len = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  seq_ready,
    output logic                  seq_valid,
    output count_pkg::count_rec_t seq_rec
);
    import count_pkg::*;

    light_t phase;
    digit_t remain;
    logic   take_tick;
    logic   xfer;

    function automatic digit_t phase_len(light_t l);
        case (l)
            red:     return digit_t'(red_len);
            green:   return digit_t'(green_len);
            default: return digit_t'(yellow_len);
        endcase
    endfunction

    function automatic light_t next_phase(light_t l);
        case (l)
            red:     return green;
            green:   return yellow;
            default: return red;
        endcase
    endfunction

    assign take_tick = tick && !seq_valid;   // ticks while busy are dropped
    assign xfer      = seq_valid && seq_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            seq_valid <= 1'b0;
        else if (take_tick)
            seq_valid <= 1'b1;
        else if (xfer)
            seq_valid <= 1'b0;
    end

    // step only once the record has left
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase  <= red;
            remain <= digit_t'(red_len);
        end
        else if (xfer)
        begin
            if (remain == '0)
            begin
                phase  <= next_phase(phase);
                remain <= phase_len(next_phase(phase));
            end
            else
                remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_tick)
            seq_rec <= '{digit: remain, light: phase};
    end

    digit_in_phase: assert property (@(posedge clk) disable iff (rst)
        seq_valid |-> seq_rec.digit <= phase_len(seq_rec.light));

endmodule

//--- digit_fifo.sv
module digit_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  count_pkg::count_rec_t in_rec,
    output logic                  out_valid,
    input  logic                  out_ready,
    output count_pkg::count_rec_t out_rec
);
    import count_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(fifo_depth - 1);

    count_rec_t       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count != cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;
    assign out_rec   = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= in_rec;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // full fifo must hold the writer off without losing its record
    full_holds_writer: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_rec));

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= cnt_w'(fifo_depth));

endmodule

//--- glyph_rom.sv
module glyph_rom (
    input  logic                                clk,
    input  logic                                rst,
    input  count_pkg::digit_t                   digit,
    input  count_pkg::light_t                   light,
    input  matrix_pkg::row_idx_t                row_idx,
    output logic [matrix_pkg::matrix_rows-1:0]  col_red,
    output logic [matrix_pkg::matrix_rows-1:0]  col_green
);
    import count_pkg::*;
    import matrix_pkg::*;

    // row 0 on top, bit 7 leftmost
    localparam logic [matrix_rows-1:0] glyph_tab [0:max_digit][0:matrix_rows-1] = '{
        '{  // 0
            8'b0011_1100,
            8'b0110_0110,
            8'b0110_1110,
            8'b0111_0110,
            8'b0110_0110,
            8'b0110_0110,
            8'b0011_1100,
            8'b0000_0000
        },
        '{  // 1
            8'b0001_1000,
            8'b0011_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0111_1110,
            8'b0000_0000
        },
        '{  // 2
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0000_1100,
            8'b0011_0000,
            8'b0110_0000,
            8'b0111_1110,
            8'b0000_0000
        },
        '{  // 3
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0001_1100,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100,
            8'b0000_0000
        },
        '{  // 4
            8'b0000_1100,
            8'b0001_1100,
            8'b0010_1100,
            8'b0100_1100,
            8'b0111_1110,
            8'b0000_1100,
            8'b0000_1100,
            8'b0000_0000
        },
        '{  // 5
            8'b0111_1110,
            8'b0110_0000,
            8'b0111_1100,
            8'b0000_0110,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100,
            8'b0000_0000
        }
    };

    logic [matrix_rows-1:0] word;

    assign word = (digit <= max_digit) ? glyph_tab[digit][row_idx] : '0;

    // yellow lights both colours
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            col_red   <= '0;
            col_green <= '0;
        end
        else
        begin
            case (light)
                red:
                begin
                    col_red   <= word;
                    col_green <= '0;
                end
                green:
                begin
                    col_red   <= '0;
                    col_green <= word;
                end
                yellow:
                begin
                    col_red   <= word;
                    col_green <= word;
                end
                default:
                begin
                    col_red   <= '0;
                    col_green <= '0;
                end
            endcase
        end
    end

endmodule

//--- matrix_pkg.sv
package matrix_pkg;

    // rows per frame, also width of a column word
    localparam int matrix_rows = 8;

    typedef logic [2:0] row_idx_t;

    // one registered word of matrix drive
    typedef struct packed {
        logic [matrix_rows-1:0] row;       // active low
        logic [matrix_rows-1:0] col_red;
        logic [matrix_rows-1:0] col_green;
    } matrix_drive_t;

endpackage

//--- matrix_scan.sv
module matrix_scan #(
    parameter int frames_per_digit = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  count_pkg::count_rec_t     in_rec,
    output matrix_pkg::matrix_drive_t drive
);
    import count_pkg::*;
    import matrix_pkg::*;

    localparam int frm_w = (frames_per_digit > 1) ? $clog2(frames_per_digit) : 1;
    localparam logic [frm_w-1:0] last_frame = frm_w'(frames_per_digit - 1);
    localparam row_idx_t last_row = row_idx_t'(matrix_rows - 1);

    row_idx_t               row_cnt;
    logic [frm_w-1:0]       frame_cnt;   // frames already finished
    count_rec_t             cur_rec;
    logic                   loaded;
    logic                   shown;       // loaded, lined up with rom output
    logic [matrix_rows-1:0] row_q;
    logic [matrix_rows-1:0] rom_red;
    logic [matrix_rows-1:0] rom_green;
    logic                   take;

    // swap records only at a frame boundary
    assign in_ready = (row_cnt == last_row) && (!loaded || frame_cnt == last_frame);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_cnt <= '0;
        else
            row_cnt <= (row_cnt == last_row) ? '0 : row_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            loaded    <= 1'b0;
            frame_cnt <= '0;
        end
        else if (take)
        begin
            loaded    <= 1'b1;
            frame_cnt <= '0;
        end
        else if (loaded && row_cnt == last_row && frame_cnt != last_frame)
            frame_cnt <= frame_cnt + 1'b1;   // saturates, keeps showing if starved
    end

    always_ff @(posedge clk)
    begin
        if (take)
            cur_rec <= in_rec;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_q <= '1;
            shown <= 1'b0;
        end
        else
        begin
            shown <= loaded;
            row_q <= loaded ? ~(matrix_rows'(1) << row_cnt) : '1;
        end
    end

    glyph_rom u_glyph_rom (
        .clk       (clk),
        .rst       (rst),
        .digit     (cur_rec.digit),
        .light     (cur_rec.light),
        .row_idx   (row_cnt),
        .col_red   (rom_red),
        .col_green (rom_green)
    );

    assign drive.row       = row_q;
    assign drive.col_red   = shown ? rom_red : '0;
    assign drive.col_green = shown ? rom_green : '0;

    row_one_cold: assert property (@(posedge clk) disable iff (rst)
        $onehot(~drive.row) || drive.row == '1);

endmodule

//--- sources.f
count_pkg.sv
matrix_pkg.sv
glyph_rom.sv
countdown_seq.sv
digit_fifo.sv
matrix_scan.sv
countdown_display.sv
tb_countdown_display.sv

//--- tb_countdown_display.sv
module tb_countdown_display;
    timeunit 1ns;
    timeprecision 1ps;

    import count_pkg::*;
    import matrix_pkg::*;

    localparam int frames_per_digit = 4;
    localparam int cycle_len        = 16;   // records in one light cycle
    localparam int num_steps        = 2 * cycle_len;
    localparam int start_timeout    = 400;

    // one light cycle, red 5..0, green 5..0, yellow 3..0
    localparam count_rec_t exp_tab [cycle_len] = '{
        '{3'd5, red},    '{3'd4, red},    '{3'd3, red},    '{3'd2, red},
        '{3'd1, red},    '{3'd0, red},    '{3'd5, green},  '{3'd4, green},
        '{3'd3, green},  '{3'd2, green},  '{3'd1, green},  '{3'd0, green},
        '{3'd3, yellow}, '{3'd2, yellow}, '{3'd1, yellow}, '{3'd0, yellow}
    };

    // glyphs as 8 row bytes, row 0 in the top byte
    localparam logic [63:0] glyph_bits [6] = '{
        64'h3c66_6e76_6666_3c00,
        64'h1838_1818_1818_7e00,
        64'h3c66_060c_3060_7e00,
        64'h3c66_061c_0666_3c00,
        64'h0c1c_2c4c_7e0c_0c00,
        64'h7e60_7c06_0666_3c00
    };

    logic          clk;
    logic          rst;
    logic          tick;
    matrix_drive_t drive;
    integer        seed;

    countdown_display u_countdown_display (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .drive (drive)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ticks at random gaps, most of them get dropped
    initial
    begin
        int gap;
        seed = 32'h553b;
        tick = 1'b0;
        repeat (3) @(posedge clk);
        forever
        begin
            gap = 1 + ($unsigned($random(seed)) % 3);
            @(posedge clk);
            tick <= 1'b1;
            @(posedge clk);
            tick <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
    end

    function automatic logic [7:0] glyph_row(digit_t d, int r);
        return glyph_bits[d][63 - 8 * r -: 8];
    endfunction

    task automatic stop_on_failure(string why);
        $display("*** FAILED ***");
        $fatal(1, why);
    endtask

    task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure("value mismatch");
        end
    endtask

    task automatic check_blank(string name);
        check_val({name, " row"}, 32'hff, drive.row);
        check_val({name, " red"}, 32'h0, drive.col_red);
        check_val({name, " green"}, 32'h0, drive.col_green);
    endtask

    // sampled at negedge, drive is registered on posedge
    task automatic wait_frame_start(input bit first, output int waited);
        bit found;
        found  = 1'b0;
        waited = 0;
        while (!found)
        begin
            @(negedge clk);
            waited++;
            if (drive.row == 8'hfe)
                found = 1'b1;
            else
            begin
                if (first)
                    check_blank("before first record");
                if (waited >= start_timeout)
                begin
                    $display("timeout: no frame start seen within %0d cycles", start_timeout);
                    stop_on_failure("frame start timeout");
                end
            end
        end
    endtask

    task automatic check_frame(string tname, count_rec_t rec);
        logic [7:0] exp_row;
        logic [7:0] exp_word;
        logic [7:0] exp_red;
        logic [7:0] exp_green;
        for (int r = 0; r < matrix_rows; r++)
        begin
            if (r > 0)
                @(negedge clk);
            exp_row   = ~(8'h01 << r);
            exp_word  = glyph_row(rec.digit, r);
            exp_red   = (rec.light == green) ? 8'h00 : exp_word;
            exp_green = (rec.light == red) ? 8'h00 : exp_word;
            check_val($sformatf("%s row %0d select", tname, r), exp_row, drive.row);
            check_val($sformatf("%s row %0d red", tname, r), exp_red, drive.col_red);
            check_val($sformatf("%s row %0d green", tname, r), exp_green, drive.col_green);
        end
    endtask

    initial
    begin
        int         waited;
        bit         first;
        count_rec_t rec;
        string      tname;
        rst = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            check_blank("in reset");
        end
        @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < num_steps; n++)
        begin
            rec = exp_tab[n % cycle_len];
            for (int f = 0; f < frames_per_digit; f++)
            begin
                first = (n == 0) && (f == 0);
                tname = $sformatf("step %0d frame %0d", n, f);
                wait_frame_start(first, waited);
                if (!first)
                    check_val({tname, " gap"}, 32'd1, waited);   // frames back to back
                check_frame(tname, rec);
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule
